// ==== verilog/div_pkg.sv ====
/*
  shared widths, operation codes and types of the RV64 divide unit
  XLEN and HALF_XLEN are fixed, the operation set assumes 64/32 bits
  operation codes are one-hot, OP_NONE marks a result that is already final
*/
package div_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int XLEN      = 64;  // register width
  localparam int HALF_XLEN = 32;  // width of the W forms
  localparam int CNT_W     = 7;   // holds 0..64

  typedef logic [XLEN-1:0]  xlen_t;    // operand or result word
  typedef logic [7:0]       div_op_t;  // one-hot operation code
  typedef logic [CNT_W-1:0] cnt_t;     // iteration count

  // ==========================================================================
  // operation codes
  // ==========================================================================
  // remainder forms in the upper nibble
  localparam div_op_t OP_REM   = 8'b1000_0000;  // signed, 64 bit
  localparam div_op_t OP_REMU  = 8'b0100_0000;  // unsigned, 64 bit
  localparam div_op_t OP_REMUW = 8'b0010_0000;  // unsigned, 32 bit
  localparam div_op_t OP_REMW  = 8'b0001_0000;  // signed, 32 bit

  // divide forms in the lower nibble
  localparam div_op_t OP_DIV   = 8'b0000_1000;  // signed, 64 bit
  localparam div_op_t OP_DIVU  = 8'b0000_0100;  // unsigned, 64 bit
  localparam div_op_t OP_DIVUW = 8'b0000_0010;  // unsigned, 32 bit
  localparam div_op_t OP_DIVW  = 8'b0000_0001;  // signed, 32 bit

  // quotient half already holds the final value (zero divisor, overflow)
  localparam div_op_t OP_NONE  = 8'b0000_0000;

  // ==========================================================================
  // control
  // ==========================================================================
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,  // waiting for a start
    ST_ITER = 2'd1,  // shift-subtract loop
    ST_DONE = 2'd2   // result valid, waiting for ready
  } div_state_e;

endpackage

// ==== verilog/div_operand_prep.sv ====
/*
  combinational operand preparation for the divide unit
  W forms use only the low 32 bits of both operands
  abs_dividend_o is left-aligned in the low half for W forms so the
  core needs only 32 iterations; exc_value_o is only meaningful with exc_hit_o
*/
`timescale 1ns/1ps

module div_operand_prep
  import div_pkg::*;
(
  input  div_op_t div_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  output xlen_t   abs_dividend_o,
  output xlen_t   abs_divisor_o,
  output cnt_t    iter_count_o,
  output logic    quot_neg_o,
  output logic    rem_neg_o,
  output logic    exc_hit_o,
  output xlen_t   exc_value_o
);

  // operation class
  logic  is_w;
  logic  is_signed;
  logic  is_rem;

  // extended operands and their magnitudes
  xlen_t dvd_sext32;
  xlen_t dvd_ext;
  xlen_t dvs_ext;
  logic  dvd_neg;
  logic  dvs_neg;
  xlen_t dvd_abs;
  xlen_t dvs_abs;

  // special cases
  xlen_t min_val;
  logic  div_zero;
  logic  div_ovf;

  // ==========================================================================
  // decode
  // ==========================================================================
  assign is_w      = |(div_op_i & (OP_REMUW | OP_REMW | OP_DIVUW | OP_DIVW));
  assign is_signed = |(div_op_i & (OP_REM | OP_REMW | OP_DIV | OP_DIVW));
  assign is_rem    = |(div_op_i & (OP_REM | OP_REMU | OP_REMUW | OP_REMW));

  // ==========================================================================
  // operand extension and absolute values
  // ==========================================================================
  assign dvd_sext32 = {{HALF_XLEN{dividend_i[HALF_XLEN-1]}}, dividend_i[HALF_XLEN-1:0]};

  always_comb begin
    if (!is_w) begin
      dvd_ext = dividend_i;
      dvs_ext = divisor_i;
    end else if (is_signed) begin
      dvd_ext = dvd_sext32;
      dvs_ext = {{HALF_XLEN{divisor_i[HALF_XLEN-1]}}, divisor_i[HALF_XLEN-1:0]};
    end else begin
      dvd_ext = {{HALF_XLEN{1'b0}}, dividend_i[HALF_XLEN-1:0]};
      dvs_ext = {{HALF_XLEN{1'b0}}, divisor_i[HALF_XLEN-1:0]};
    end
  end

  assign dvd_neg = is_signed & dvd_ext[XLEN-1];
  assign dvs_neg = is_signed & dvs_ext[XLEN-1];

  // for W forms the negated value fits in the low 32 bits, upper half is zero
  assign dvd_abs = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
  assign dvs_abs = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

  assign abs_dividend_o = is_w ? {dvd_abs[HALF_XLEN-1:0], {HALF_XLEN{1'b0}}} : dvd_abs;
  assign abs_divisor_o  = dvs_abs;
  assign iter_count_o   = is_w ? cnt_t'(HALF_XLEN) : cnt_t'(XLEN);

  assign quot_neg_o = dvd_neg ^ dvs_neg;  // signs differ
  assign rem_neg_o  = dvd_neg;            // remainder follows dividend

  // ==========================================================================
  // zero divisor and signed overflow
  // ==========================================================================
  // most negative value, as seen after extension
  assign min_val = is_w ? {{(HALF_XLEN+1){1'b1}}, {(HALF_XLEN-1){1'b0}}}
                        : {1'b1, {(XLEN-1){1'b0}}};

  assign div_zero = ~|dvs_ext;  // W forms look at 32 bits only
  assign div_ovf  = is_signed & (dvd_ext == min_val) & (&dvs_ext);

  assign exc_hit_o = div_zero | div_ovf;

  // dvd_w is the dividend as the spec returns it, sign-extended for W
  always_comb begin
    xlen_t dvd_w;
    dvd_w = is_w ? dvd_sext32 : dividend_i;
    if (div_zero) begin
      exc_value_o = is_rem ? dvd_w : {XLEN{1'b1}};
    end else begin
      exc_value_o = is_rem ? {XLEN{1'b0}} : dvd_w;  // overflow
    end
  end

endmodule

// ==== verilog/div_iter_core.sv ====
/*
  restoring shift-subtract divider core, one quotient bit per cycle
  operands must already be magnitudes; signs are only carried along
  a start is taken only in ST_IDLE, the result is held in ST_DONE until
  result_ready_i; no flush of a running operation
*/
`timescale 1ns/1ps

module div_iter_core
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_t div_op_i,
  input  logic    result_ready_i,
  input  xlen_t   abs_dividend_i,
  input  xlen_t   abs_divisor_i,
  input  cnt_t    iter_count_i,
  input  logic    quot_neg_i,
  input  logic    rem_neg_i,
  input  logic    exc_hit_i,
  input  xlen_t   exc_value_i,
  output div_op_t op_o,
  output logic    quot_neg_o,
  output logic    rem_neg_o,
  output xlen_t   quotient_o,
  output xlen_t   remainder_o,
  output logic    busy_o,
  output logic    done_o
);

  div_state_e state_q;
  div_state_e state_d;

  cnt_t    cnt_q;
  div_op_t op_q;
  logic    quot_neg_q;
  logic    rem_neg_q;

  // datapath, loaded on start
  logic [2*XLEN-1:0] work_q;  // {remainder, quotient}
  xlen_t             divisor_q;

  logic              start;
  logic              iterate;
  logic [2*XLEN-1:0] work_shl;
  logic [XLEN:0]     diff;
  logic [2*XLEN-1:0] work_step;

  assign start   = (state_q == ST_IDLE) && div_valid_i;
  assign iterate = (state_q == ST_ITER) && (cnt_q != '0);

  // ==========================================================================
  // state machine
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (div_valid_i) begin
          state_d = exc_hit_i ? ST_DONE : ST_ITER;  // special cases skip the loop
        end
      end
      ST_ITER: begin
        if (cnt_q == '0) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        if (result_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= ST_IDLE;
      cnt_q      <= '0;
      op_q       <= OP_NONE;
      quot_neg_q <= 1'b0;
      rem_neg_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        if (exc_hit_i) begin
          cnt_q      <= '0;
          op_q       <= OP_NONE;  // result is final as loaded
          quot_neg_q <= 1'b0;
          rem_neg_q  <= 1'b0;
        end else begin
          cnt_q      <= iter_count_i;
          op_q       <= div_op_i;
          quot_neg_q <= quot_neg_i;
          rem_neg_q  <= rem_neg_i;
        end
      end else if (iterate) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ==========================================================================
  // shift-subtract datapath
  // ==========================================================================
  assign work_shl = work_q << 1;

  // upper 65 bits of the shifted register minus the divisor
  assign diff = work_q[2*XLEN-1:XLEN-1] - {1'b0, divisor_q};

  // negative difference restores, otherwise keep it and set the quotient bit
  assign work_step = diff[XLEN] ? work_shl
                                : {diff[XLEN-1:0], work_shl[XLEN-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (start) begin
      divisor_q <= abs_divisor_i;
      if (exc_hit_i) begin
        work_q <= {{XLEN{1'b0}}, exc_value_i};
      end else begin
        work_q <= {{XLEN{1'b0}}, abs_dividend_i};
      end
    end else if (iterate) begin
      work_q <= work_step;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================
  assign op_o        = op_q;
  assign quot_neg_o  = quot_neg_q;
  assign rem_neg_o   = rem_neg_q;
  assign quotient_o  = work_q[XLEN-1:0];
  assign remainder_o = work_q[2*XLEN-1:XLEN];

  // busy already in the accepting cycle of a looping start
  assign busy_o = (start && !exc_hit_i) || (state_q == ST_ITER);
  assign done_o = (state_q == ST_DONE);

endmodule

// ==== verilog/div_result_sel.sv ====
/*
  combinational result selection for the divide unit
  inputs are the raw magnitudes of quotient and remainder plus saved signs
  unsigned forms arrive with both signs cleared
  OP_NONE or any unknown code passes the quotient half through
*/
`timescale 1ns/1ps

module div_result_sel
  import div_pkg::*;
(
  input  div_op_t op_i,
  input  logic    quot_neg_i,
  input  logic    rem_neg_i,
  input  xlen_t   quotient_i,
  input  xlen_t   remainder_i,
  output xlen_t   result_o
);

  xlen_t quot_fix;  // signed quotient
  xlen_t rem_fix;   // signed remainder
  xlen_t quot_w;
  xlen_t rem_w;

  // ==========================================================================
  // sign correction
  // ==========================================================================
  assign quot_fix = quot_neg_i ? (~quotient_i + 1'b1) : quotient_i;
  assign rem_fix  = rem_neg_i  ? (~remainder_i + 1'b1) : remainder_i;

  // W results, sign-extended from bit 31 even for the unsigned forms
  assign quot_w = {{HALF_XLEN{quot_fix[HALF_XLEN-1]}}, quot_fix[HALF_XLEN-1:0]};
  assign rem_w  = {{HALF_XLEN{rem_fix[HALF_XLEN-1]}}, rem_fix[HALF_XLEN-1:0]};

  // ==========================================================================
  // one-hot lookup
  // ==========================================================================
  always_comb begin
    unique case (op_i)
      OP_DIV,
      OP_DIVU:  result_o = quot_fix;
      OP_REM,
      OP_REMU:  result_o = rem_fix;
      OP_DIVW,
      OP_DIVUW: result_o = quot_w;
      OP_REMW,
      OP_REMUW: result_o = rem_w;
      default:  result_o = quotient_i;  // OP_NONE, value already final
    endcase
  end

endmodule

// ==== verilog/rv_divider.sv ====
/*
  RV64 M-extension divide unit, one operation at a time
  div_valid_i is sampled only while idle, other strobes are dropped
  result_valid_o holds with a stable result until result_ready_i
  latency 66 cycles (64 bit) or 34 cycles (W), special cases in one
*/
`timescale 1ns/1ps

module rv_divider
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_t div_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    result_ready_i,
  output xlen_t   div_result_o,
  output logic    div_busy_o,
  output logic    result_valid_o
);

  // prep to core
  xlen_t   abs_dividend;
  xlen_t   abs_divisor;
  cnt_t    iter_count;
  logic    quot_neg;
  logic    rem_neg;
  logic    exc_hit;
  xlen_t   exc_value;

  // core to result select
  div_op_t op_q;
  logic    quot_neg_q;
  logic    rem_neg_q;
  xlen_t   quotient_q;
  xlen_t   remainder_q;

  div_operand_prep u_prep (
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .abs_dividend_o (abs_dividend),
    .abs_divisor_o  (abs_divisor),
    .iter_count_o   (iter_count),
    .quot_neg_o     (quot_neg),
    .rem_neg_o      (rem_neg),
    .exc_hit_o      (exc_hit),
    .exc_value_o    (exc_value)
  );

  div_iter_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .result_ready_i (result_ready_i),
    .abs_dividend_i (abs_dividend),
    .abs_divisor_i  (abs_divisor),
    .iter_count_i   (iter_count),
    .quot_neg_i     (quot_neg),
    .rem_neg_i      (rem_neg),
    .exc_hit_i      (exc_hit),
    .exc_value_i    (exc_value),
    .op_o           (op_q),
    .quot_neg_o     (quot_neg_q),
    .rem_neg_o      (rem_neg_q),
    .quotient_o     (quotient_q),
    .remainder_o    (remainder_q),
    .busy_o         (div_busy_o),
    .done_o         (result_valid_o)
  );

  div_result_sel u_sel (
    .op_i        (op_q),
    .quot_neg_i  (quot_neg_q),
    .rem_neg_i   (rem_neg_q),
    .quotient_i  (quotient_q),
    .remainder_i (remainder_q),
    .result_o    (div_result_o)
  );

endmodule

// ==== bench/rv_divider_assertions.sv ====
/*
  protocol assertions for the divide unit, bound into rv_divider
  rst_n is active high, checks pause while it is asserted
  except the one that looks at the reset itself
*/
`timescale 1ns/1ps

module rv_divider_assertions
  import div_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  result_ready_i,
  input logic  result_valid_o,
  input logic  div_busy_o,
  input xlen_t div_result_o
);

  // valid only in ST_DONE, busy only around the loop
  a_valid_busy_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(result_valid_o && div_busy_o))
    else $error("result_valid_o and div_busy_o high together");

  // back-pressure holds both level and value
  a_result_stable: assert property (@(posedge clk) disable iff (rst_n)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(div_result_o))
    else $error("result dropped or changed while result_ready_i was low");

  a_valid_fall: assert property (@(posedge clk) disable iff (rst_n)
    $fell(result_valid_o) |-> $past(result_ready_i))
    else $error("result_valid_o fell without result_ready_i");

  // one edge after a reset edge both outputs are clear
  a_reset_clear: assert property (@(posedge clk)
    rst_n |=> !result_valid_o && !div_busy_o)
    else $error("outputs not cleared after reset");

endmodule

// ==== bench/rv_divider_tb.sv ====
/*
  testbench for the RV64 divide unit
  directed table first, then LFSR-random cases against a reference model
  rst_n is active high, inputs change on the falling clock edge
*/
`timescale 1ns/1ps

module rv_divider_tb
  import div_pkg::*;
();

  localparam int N_TAB  = 24;
  localparam int N_RAND = 40;
  localparam int LIMIT  = (N_TAB + N_RAND) * 80 + 16;

  typedef struct packed {
    div_op_t    op;
    xlen_t      a;
    xlen_t      b;
    xlen_t      exp;
    logic [3:0] dly;  // cycles with result_ready_i low
  } vec_t;

  logic    clk;
  logic    rst_n;
  logic    div_valid_i;
  div_op_t div_op_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    result_ready_i;
  xlen_t   div_result_o;
  logic    div_busy_o;
  logic    result_valid_o;

  logic [31:0] lfsr;
  int          cycles;
  int          n_pass;
  int          n_fail;

  // ==========================================================================
  // directed cases
  // ==========================================================================
  vec_t tab [N_TAB] = '{
    '{OP_DIV,   -64'sd7, 64'd2,   -64'sd3, 4'd0},  // rounds toward zero
    '{OP_REM,   -64'sd7, 64'd2,   -64'sd1, 4'd1},  // sign of dividend
    '{OP_DIV,   64'd7,   -64'sd2, -64'sd3, 4'd0},
    '{OP_REM,   64'd7,   -64'sd2, 64'd1,   4'd2},
    '{OP_DIV,   -64'sd7, -64'sd2, 64'd3,   4'd0},
    '{OP_REM,   -64'sd7, -64'sd2, -64'sd1, 4'd0},
    '{OP_DIVU,  -64'sd7, 64'd2,   64'h7ffffffffffffffc, 4'd3},
    '{OP_REMU,  -64'sd7, 64'd2,   64'd1,   4'd0},
    '{OP_DIVW,  64'hdeadbeeffffffff9, 64'h1234567800000002, -64'sd3, 4'd0},
    '{OP_REMW,  64'hdeadbeeffffffff9, 64'h1234567800000002, -64'sd1, 4'd1},
    '{OP_DIVUW, 64'h11111111fffffffe, 64'hffffffff00000001, -64'sd2, 4'd0},
    '{OP_REMUW, 64'h0000000080000005, 64'haaaaaaaa90000000, 64'hffffffff80000005, 4'd4},
    // zero divisor and overflow
    '{OP_DIV,   64'd42,  64'd0,   -64'sd1, 4'd0},
    '{OP_REM,   -64'sd5, 64'd0,   -64'sd5, 4'd2},
    '{OP_DIVU,  64'd5,   64'd0,   -64'sd1, 4'd0},
    '{OP_REMU,  64'h1234, 64'd0,  64'h1234, 4'd0},
    '{OP_DIV,   64'h8000000000000000, -64'sd1, 64'h8000000000000000, 4'd1},
    '{OP_REM,   64'h8000000000000000, -64'sd1, 64'd0, 4'd0},
    '{OP_DIVW,  64'h0000000080000000, 64'h00000000ffffffff, 64'hffffffff80000000, 4'd0},
    '{OP_REMW,  64'h0000000080000000, 64'h00000000ffffffff, 64'd0, 4'd5},
    '{OP_DIVW,  64'd9,   64'h1234567800000000, -64'sd1, 4'd0},  // upper half ignored
    '{OP_REMW,  64'h00000000fffffff0, 64'hffffffff00000000, 64'hfffffffffffffff0, 4'd3},
    '{OP_DIVUW, 64'd7,   64'hffffffff00000000, -64'sd1, 4'd0},  // low half zero
    '{OP_REMUW, 64'h5555555580000001, 64'h0000000100000000, 64'hffffffff80000001, 4'd6}
  };

  rv_divider UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_result_o   (div_result_o),
    .div_busy_o     (div_busy_o),
    .result_valid_o (result_valid_o)
  );

  bind rv_divider rv_divider_assertions u_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .result_ready_i (result_ready_i),
    .result_valid_o (result_valid_o),
    .div_busy_o     (div_busy_o),
    .div_result_o   (div_result_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout, a result never arrived within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ==========================================================================
  // reference model and random source
  // ==========================================================================
  function automatic bit is_word(input div_op_t op);
    return (op == OP_DIVW) || (op == OP_DIVUW) || (op == OP_REMW) || (op == OP_REMUW);
  endfunction

  function automatic xlen_t model_result(input div_op_t op, input xlen_t a, input xlen_t b,
                                         output bit special);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        r32;
    xlen_t              dvd;
    xlen_t              r;
    bit                 sgn;
    bit                 rem;
    bit                 zero;
    bit                 ovf;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    r    = '0;
    r32  = '0;
    sgn  = (op == OP_DIV) || (op == OP_REM) || (op == OP_DIVW) || (op == OP_REMW);
    rem  = (op == OP_REM) || (op == OP_REMU) || (op == OP_REMW) || (op == OP_REMUW);
    dvd  = is_word(op) ? {{32{a[31]}}, a[31:0]} : a;
    zero = is_word(op) ? (b[31:0] == 32'd0) : (b == 64'd0);
    if (is_word(op)) ovf = sgn && (wa == 32'sh80000000) && (wb == -32'sd1);
    else ovf = sgn && (a == 64'h8000000000000000) && (sb == -64'sd1);
    special = zero || ovf;
    if (zero) begin
      r = rem ? dvd : '1;
    end else if (ovf) begin
      r = rem ? '0 : dvd;
    end else begin
      case (op)
        OP_DIV:   r = sa / sb;
        OP_DIVU:  r = a / b;
        OP_REM:   r = sa % sb;
        OP_REMU:  r = a % b;
        OP_DIVW:  r32 = wa / wb;
        OP_DIVUW: r32 = a[31:0] / b[31:0];
        OP_REMW:  r32 = wa % wb;
        default:  r32 = a[31:0] % b[31:0];  // REMUW
      endcase
      if (is_word(op)) r = {{32{r32[31]}}, r32};
    end
    return r;
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output xlen_t v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
  endtask

  // ==========================================================================
  // one operation with latency, back-pressure and stray strobes
  // ==========================================================================
  task automatic run_case(input int idx, input div_op_t op, input xlen_t a, input xlen_t b,
                          input xlen_t exp, input bit special, input int dly);
    int    lat;
    int    exp_lat;
    int    errs;
    errs    = 0;
    exp_lat = special ? 1 : (is_word(op) ? 34 : 66);
    div_op_i       = op;
    dividend_i     = a;
    divisor_i      = b;
    div_valid_i    = 1'b1;
    result_ready_i = 1'b0;
    @(posedge clk);  // accepting edge
    @(negedge clk);
    lat         = 1;
    div_valid_i = 1'b0;
    while (!result_valid_o) begin
      if (!div_busy_o) begin
        $display("ERR t=%0t div_busy_o exp 1 got 0", $time);
        errs++;
      end
      div_valid_i = (lat == 2);  // strobe while busy with other operands
      dividend_i  = ~a;
      divisor_i   = b ^ 64'h5;
      @(negedge clk);
      lat++;
    end
    if (lat != exp_lat) begin
      $display("ERR t=%0t result_valid_o latency exp %0d got %0d", $time, exp_lat, lat);
      errs++;
    end
    if (div_result_o !== exp) begin
      $display("ERR t=%0t div_result_o exp %h got %h", $time, exp, div_result_o);
      errs++;
    end
    repeat (dly) begin
      div_valid_i = 1'b1;  // strobe while done
      @(negedge clk);
      if (!result_valid_o) begin
        $display("ERR t=%0t result_valid_o exp 1 got 0", $time);
        errs++;
      end
      if (div_result_o !== exp) begin
        $display("ERR t=%0t div_result_o exp %h got %h", $time, exp, div_result_o);
        errs++;
      end
    end
    div_valid_i    = 1'b0;
    result_ready_i = 1'b1;
    @(negedge clk);
    result_ready_i = 1'b0;
    if (result_valid_o) begin
      $display("ERR t=%0t result_valid_o exp 0 got 1", $time);
      errs++;
    end
    if (errs == 0) n_pass++;
    else n_fail++;
    $display("test %0d op %b a %h b %h: %s", idx, op, a, b, (errs == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    xlen_t   sel;
    xlen_t   a;
    xlen_t   b;
    xlen_t   sh;
    xlen_t   dly;
    xlen_t   exp;
    div_op_t op;
    bit      special;
    clk            = 1'b0;
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    div_op_i       = OP_NONE;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    lfsr           = 32'hfcd9;
    cycles         = 0;
    n_pass         = 0;
    n_fail         = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);

    for (int i = 0; i < N_TAB; i++) begin
      void'(model_result(tab[i].op, tab[i].a, tab[i].b, special));  // latency class
      run_case(i, tab[i].op, tab[i].a, tab[i].b, tab[i].exp, special, int'(tab[i].dly));
    end

    for (int i = 0; i < N_RAND; i++) begin
      take_bits(3, sel);
      take_bits(64, a);
      take_bits(64, b);
      take_bits(6, sh);
      take_bits(3, dly);
      b   = b >> sh[5:0];  // spread of divisor sizes
      op  = div_op_t'(8'b1 << sel[2:0]);
      exp = model_result(op, a, b, special);
      run_case(N_TAB + i, op, a, b, exp, special, int'(dly));
    end

    $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_iter_core.sv
verilog/div_result_sel.sv
verilog/rv_divider.sv
bench/rv_divider_assertions.sv
bench/rv_divider_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := rv_divider_tb
FILELIST := build.f
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
